//--- cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// word and line geometry
`define CACHE_WORD_W      16
`define CACHE_LINE_WORDS  4
`define CACHE_LINE_W      64

// two sets, address = tag | index | word offset
`define CACHE_SETS        2
`define CACHE_OFFSET_W    2
`define CACHE_INDEX_W     1
`define CACHE_TAG_W       13
`define CACHE_ADDR_W      16

// tag entry layout
// tag sits in the low bits, state bits above it
`define CACHE_ENTRY_VALID  13
`define CACHE_ENTRY_DIRTY  14
`define CACHE_ENTRY_RECENT 15
`define CACHE_ENTRY_W      16

`endif

//--- cache_pkg.sv
`include "cache_cfg.svh"

package cache_pkg;

    // one cache line, seen either as a flat vector or as words
    // word 0 is in the low bits
    typedef union packed {
        logic [`CACHE_LINE_W-1:0] flat;
        logic [`CACHE_LINE_WORDS-1:0][`CACHE_WORD_W-1:0] words;
    } cache_line_u;

endpackage

//--- cache_tag_array.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_tag_array (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic [`CACHE_INDEX_W-1:0] set_index,
    input  logic                      tag_we0,
    input  logic                      tag_we1,
    input  logic [`CACHE_TAG_W-1:0]   tag_wr_tag,
    input  logic                      tag_wr_dirty,
    input  logic                      tag_wr_valid,
    input  logic                      tag_wr_recent0,
    input  logic                      tag_wr_recent1,
    output logic [`CACHE_TAG_W-1:0]   tag_way0_tag,
    output logic                      tag_way0_valid,
    output logic                      tag_way0_dirty,
    output logic                      tag_way0_recent,
    output logic [`CACHE_TAG_W-1:0]   tag_way1_tag,
    output logic                      tag_way1_valid,
    output logic                      tag_way1_dirty,
    output logic                      tag_way1_recent
);

    // entries[set][way]
    logic [`CACHE_ENTRY_W-1:0] entries [`CACHE_SETS][2];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            // only the state bits are cleared, tags stay as they are
            for (int s = 0; s < `CACHE_SETS; s++) begin
                for (int w = 0; w < 2; w++) begin
                    entries[s][w][`CACHE_ENTRY_VALID]  <= 1'b0;
                    entries[s][w][`CACHE_ENTRY_DIRTY]  <= 1'b0;
                    entries[s][w][`CACHE_ENTRY_RECENT] <= 1'b0;
                end
            end
        end else begin
            if (tag_we0) begin
                entries[set_index][0][`CACHE_TAG_W-1:0]   <= tag_wr_tag;
                entries[set_index][0][`CACHE_ENTRY_VALID] <= tag_wr_valid;
                entries[set_index][0][`CACHE_ENTRY_DIRTY] <= tag_wr_dirty;
            end
            if (tag_we1) begin
                entries[set_index][1][`CACHE_TAG_W-1:0]   <= tag_wr_tag;
                entries[set_index][1][`CACHE_ENTRY_VALID] <= tag_wr_valid;
                entries[set_index][1][`CACHE_ENTRY_DIRTY] <= tag_wr_dirty;
            end
            // recent bits of both ways move together on any write to the set
            if (tag_we0 || tag_we1) begin
                entries[set_index][0][`CACHE_ENTRY_RECENT] <= tag_wr_recent0;
                entries[set_index][1][`CACHE_ENTRY_RECENT] <= tag_wr_recent1;
            end
        end
    end

    assign tag_way0_tag    = entries[set_index][0][`CACHE_TAG_W-1:0];
    assign tag_way0_valid  = entries[set_index][0][`CACHE_ENTRY_VALID];
    assign tag_way0_dirty  = entries[set_index][0][`CACHE_ENTRY_DIRTY];
    assign tag_way0_recent = entries[set_index][0][`CACHE_ENTRY_RECENT];
    assign tag_way1_tag    = entries[set_index][1][`CACHE_TAG_W-1:0];
    assign tag_way1_valid  = entries[set_index][1][`CACHE_ENTRY_VALID];
    assign tag_way1_dirty  = entries[set_index][1][`CACHE_ENTRY_DIRTY];
    assign tag_way1_recent = entries[set_index][1][`CACHE_ENTRY_RECENT];

    for (genvar s = 0; s < `CACHE_SETS; s++) begin : g_recent_chk
        a_one_recent: assert property (@(posedge clk) disable iff (!reset_n)
            !(entries[s][0][`CACHE_ENTRY_RECENT] && entries[s][1][`CACHE_ENTRY_RECENT]));
    end

endmodule

//--- cache_data_array.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_data_array
    import cache_pkg::*;
(
    input  logic                      clk,
    input  logic [`CACHE_INDEX_W-1:0] set_index,
    input  logic                      line_we0,
    input  logic                      line_we1,
    input  cache_line_u               line_wr,
    output cache_line_u               line_way0,
    output cache_line_u               line_way1
);

    // lines[set][way], contents are only meaningful behind a valid tag
    cache_line_u lines [`CACHE_SETS][2];

    always_ff @(posedge clk) begin
        if (line_we0) begin
            lines[set_index][0] <= line_wr;
        end
        if (line_we1) begin
            lines[set_index][1] <= line_wr;
        end
    end

    // both ways are read at once for hit select and write-back
    assign line_way0 = lines[set_index][0];
    assign line_way1 = lines[set_index][1];

endmodule

//--- cache_ctrl.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_ctrl
    import cache_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_n,
    // cpu side
    input  logic                      cpu_valid,
    input  logic                      cpu_write,
    input  logic [`CACHE_ADDR_W-1:0]  cpu_addr,
    input  logic [`CACHE_WORD_W-1:0]  cpu_wdata,
    output logic [`CACHE_WORD_W-1:0]  cpu_rdata,
    output logic                      cpu_ready,
    output logic                      cpu_ack,
    // memory side
    output logic                      mem_read,
    output logic                      mem_write,
    output logic [`CACHE_ADDR_W-1:0]  mem_addr,
    output cache_line_u               mem_wdata,
    input  cache_line_u               mem_rdata,
    input  logic                      mem_ready,
    input  logic                      mem_ack,
    // tag array
    output logic [`CACHE_INDEX_W-1:0] set_index,
    input  logic [`CACHE_TAG_W-1:0]   tag_way0_tag,
    input  logic                      tag_way0_valid,
    input  logic                      tag_way0_dirty,
    input  logic                      tag_way0_recent,
    input  logic [`CACHE_TAG_W-1:0]   tag_way1_tag,
    input  logic                      tag_way1_valid,
    input  logic                      tag_way1_dirty,
    input  logic                      tag_way1_recent,
    output logic                      tag_we0,
    output logic                      tag_we1,
    output logic [`CACHE_TAG_W-1:0]   tag_wr_tag,
    output logic                      tag_wr_dirty,
    output logic                      tag_wr_recent0,
    output logic                      tag_wr_recent1,
    output logic                      tag_wr_valid,
    // data array
    input  cache_line_u               line_way0,
    input  cache_line_u               line_way1,
    output logic                      line_we0,
    output logic                      line_we1,
    output cache_line_u               line_wr
);

    localparam logic [1:0] CHECK      = 2'd0;
    localparam logic [1:0] ALLOCATE   = 2'd1;
    localparam logic [1:0] WRITE_BACK = 2'd2;

    logic [1:0] state;
    logic [1:0] next_state;

    logic [`CACHE_TAG_W-1:0]    addr_tag;
    logic [`CACHE_INDEX_W-1:0]  addr_index;
    logic [`CACHE_OFFSET_W-1:0] addr_offset;

    logic hit0;
    logic hit1;
    logic hit;
    logic hit_dirty;

    logic                    victim_way;
    logic                    victim_q;
    logic                    victim_sel;
    logic [`CACHE_TAG_W-1:0] victim_tag;
    logic                    victim_dirty;
    cache_line_u             victim_line;

    logic [`CACHE_ADDR_W-1:0] victim_addr;
    logic [`CACHE_ADDR_W-1:0] fetch_addr;

    cache_line_u hit_line;
    cache_line_u src_line;
    cache_line_u merged_line;

    assign addr_tag    = cpu_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign addr_index  = cpu_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    assign addr_offset = cpu_addr[`CACHE_OFFSET_W-1:0];
    assign set_index   = addr_index;

    assign hit0      = tag_way0_valid && (tag_way0_tag == addr_tag);
    assign hit1      = tag_way1_valid && (tag_way1_tag == addr_tag);
    assign hit       = hit0 || hit1;
    assign hit_dirty = hit1 ? tag_way1_dirty : tag_way0_dirty;

    // way 0 unless way 0 is the recent one
    // (covers the case of neither way being recent)
    assign victim_way = tag_way0_recent;

    // the registered choice holds through write-back and fill
    assign victim_sel   = (state == CHECK) ? victim_way : victim_q;
    assign victim_tag   = victim_sel ? tag_way1_tag : tag_way0_tag;
    assign victim_line  = victim_sel ? line_way1 : line_way0;
    assign victim_dirty = victim_sel ? (tag_way1_valid && tag_way1_dirty)
                                     : (tag_way0_valid && tag_way0_dirty);

    assign victim_addr = {victim_tag, addr_index, {`CACHE_OFFSET_W{1'b0}}};
    assign fetch_addr  = {cpu_addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], {`CACHE_OFFSET_W{1'b0}}};
    assign mem_wdata   = victim_line;

    // word select and merge work on the hit line or the incoming fill
    assign hit_line = hit1 ? line_way1 : line_way0;
    assign src_line = (state == ALLOCATE) ? mem_rdata : hit_line;

    always_comb begin
        merged_line = src_line;
        if (cpu_write) begin
            merged_line.words[addr_offset] = cpu_wdata;
        end
    end

    assign cpu_rdata  = src_line.words[addr_offset];
    assign line_wr    = merged_line;
    assign tag_wr_tag = addr_tag;

    always_comb begin
        next_state     = state;
        cpu_ready      = 1'b0;
        cpu_ack        = 1'b0;
        mem_read       = 1'b0;
        mem_write      = 1'b0;
        mem_addr       = fetch_addr;
        tag_we0        = 1'b0;
        tag_we1        = 1'b0;
        line_we0       = 1'b0;
        line_we1       = 1'b0;
        tag_wr_dirty   = 1'b0;
        tag_wr_recent0 = 1'b0;
        tag_wr_recent1 = 1'b0;
        // a hit or a fill always leaves the entry valid
        tag_wr_valid   = 1'b1;

        case (state)
            CHECK: begin
                if (cpu_valid && hit) begin
                    cpu_ready      = !cpu_write;
                    cpu_ack        = cpu_write;
                    tag_we0        = hit0;
                    tag_we1        = hit1;
                    line_we0       = hit0 && cpu_write;
                    line_we1       = hit1 && cpu_write;
                    tag_wr_dirty   = hit_dirty || cpu_write;
                    tag_wr_recent0 = hit0;
                    tag_wr_recent1 = hit1;
                end else if (cpu_valid && victim_dirty) begin
                    mem_write  = 1'b1;
                    mem_addr   = victim_addr;
                    next_state = WRITE_BACK;
                end else if (cpu_valid) begin
                    mem_read   = 1'b1;
                    next_state = ALLOCATE;
                end
            end
            WRITE_BACK: begin
                if (mem_ack) begin
                    // write-back done, start the fetch in the same cycle
                    mem_read   = 1'b1;
                    next_state = ALLOCATE;
                end else begin
                    mem_write = 1'b1;
                    mem_addr  = victim_addr;
                end
            end
            ALLOCATE: begin
                mem_read = 1'b1;
                if (mem_ready) begin
                    cpu_ready      = !cpu_write;
                    cpu_ack        = cpu_write;
                    tag_we0        = !victim_q;
                    tag_we1        = victim_q;
                    line_we0       = !victim_q;
                    line_we1       = victim_q;
                    tag_wr_dirty   = cpu_write;
                    tag_wr_recent0 = !victim_q;
                    tag_wr_recent1 = victim_q;
                    next_state     = CHECK;
                end
            end
            default: begin
                next_state = CHECK;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state    <= CHECK;
            victim_q <= 1'b0;
        end else begin
            state <= next_state;
            if (state == CHECK && cpu_valid && !hit) begin
                victim_q <= victim_way;
            end
        end
    end

    // a response only goes to a request that is still present
    a_resp_has_req: assert property (@(posedge clk) disable iff (!reset_n)
        (cpu_ready || cpu_ack) |-> cpu_valid);

    // fill address holds until memory returns the line
    a_fill_addr_stable: assert property (@(posedge clk) disable iff (!reset_n)
        (mem_read && !mem_ready) |=> (mem_ready || (mem_read && $stable(mem_addr))));

    // victim address must not move while memory is taking the line
    a_wb_addr_stable: assert property (@(posedge clk) disable iff (!reset_n)
        (mem_write && !mem_ack) |=> (mem_ack || (mem_write && $stable(mem_addr))));

endmodule

//--- data_cache.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module data_cache
    import cache_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_n,
    // cpu side
    input  logic                      cpu_valid,
    input  logic                      cpu_write,
    input  logic [`CACHE_ADDR_W-1:0]  cpu_addr,
    input  logic [`CACHE_WORD_W-1:0]  cpu_wdata,
    output logic [`CACHE_WORD_W-1:0]  cpu_rdata,
    output logic                      cpu_ready,
    output logic                      cpu_ack,
    // memory side, one line per transfer
    output logic                      mem_read,
    output logic                      mem_write,
    output logic [`CACHE_ADDR_W-1:0]  mem_addr,
    output cache_line_u               mem_wdata,
    input  cache_line_u               mem_rdata,
    input  logic                      mem_ready,
    input  logic                      mem_ack
);

    logic [`CACHE_INDEX_W-1:0] set_index;

    logic [`CACHE_TAG_W-1:0] tag_way0_tag;
    logic                    tag_way0_valid;
    logic                    tag_way0_dirty;
    logic                    tag_way0_recent;
    logic [`CACHE_TAG_W-1:0] tag_way1_tag;
    logic                    tag_way1_valid;
    logic                    tag_way1_dirty;
    logic                    tag_way1_recent;

    logic                    tag_we0;
    logic                    tag_we1;
    logic [`CACHE_TAG_W-1:0] tag_wr_tag;
    logic                    tag_wr_dirty;
    logic                    tag_wr_valid;
    logic                    tag_wr_recent0;
    logic                    tag_wr_recent1;

    logic        line_we0;
    logic        line_we1;
    cache_line_u line_wr;
    cache_line_u line_way0;
    cache_line_u line_way1;

    cache_ctrl u_ctrl (.*);

    cache_tag_array u_tags (.*);

    cache_data_array u_lines (.*);

endmodule

//--- tb_mem_model.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module tb_mem_model
    import cache_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     mem_read,
    input  logic                     mem_write,
    input  logic [`CACHE_ADDR_W-1:0] mem_addr,
    input  cache_line_u              mem_wdata,
    output cache_line_u              mem_rdata,
    output logic                     mem_ready,
    output logic                     mem_ack,
    output int                       read_count,
    output int                       write_count,
    output logic [`CACHE_ADDR_W-1:0] last_read_addr,
    output logic [`CACHE_ADDR_W-1:0] last_write_addr
);

    localparam int CACHE_MEM_LINES = 1 << (`CACHE_ADDR_W - `CACHE_OFFSET_W);

    // only lines written back are stored, all others read as the fill pattern
    cache_line_u written [CACHE_MEM_LINES];
    bit          line_written [CACHE_MEM_LINES];
    int latency [256];

    cache_line_u rdata_q = '0;
    logic ready_q = 1'b0;
    logic ack_q = 1'b0;
    logic busy = 1'b0;
    logic busy_write;
    logic [`CACHE_ADDR_W-1:0] req_addr;
    int wait_cnt;

    assign mem_rdata = rdata_q;
    assign mem_ready = ready_q;
    assign mem_ack   = ack_q;

    // each word holds its own word address xor a5a5
    function automatic cache_line_u pattern_line(input logic [`CACHE_ADDR_W-3:0] line);
        cache_line_u l;
        for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
            l.words[w] = {line, 2'(w)} ^ 16'hA5A5;
        end
        return l;
    endfunction

    // latencies of 1 to 4 cycles, drawn once so the run is repeatable
    initial begin
        void'($urandom(45));
        for (int i = 0; i < 256; i++) begin
            latency[i] = 1 + int'($urandom % 4);
        end
    end

    always @(posedge clk) begin
        ready_q <= 1'b0;
        ack_q   <= 1'b0;
        if (!reset_n) begin
            busy            <= 1'b0;
            read_count      <= 0;
            write_count     <= 0;
            last_read_addr  <= '0;
            last_write_addr <= '0;
        end else if (!busy) begin
            // a request still seen during its own answer pulse is not a new one
            if ((mem_read || mem_write) && !ready_q && !ack_q) begin
                busy       <= 1'b1;
                busy_write <= mem_write;
                req_addr   <= mem_addr;
                wait_cnt   <= latency[(read_count + write_count) % 256] - 1;
                if (mem_write) begin
                    write_count     <= write_count + 1;
                    last_write_addr <= mem_addr;
                    $display("mem: line write at 0x%04h", mem_addr);
                end else begin
                    read_count     <= read_count + 1;
                    last_read_addr <= mem_addr;
                    $display("mem: line read at 0x%04h", mem_addr);
                end
            end
        end else if (wait_cnt != 0) begin
            wait_cnt <= wait_cnt - 1;
        end else begin
            busy <= 1'b0;
            if (busy_write) begin
                written[req_addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W]]      <= mem_wdata;
                line_written[req_addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W]] <= 1'b1;
                ack_q <= 1'b1;
            end else begin
                if (line_written[req_addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W]]) begin
                    rdata_q <= written[req_addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W]];
                end else begin
                    rdata_q <= pattern_line(req_addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W]);
                end
                ready_q <= 1'b1;
            end
        end
    end

endmodule

//--- tb_data_cache.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module tb_data_cache
    import cache_pkg::*;
();

    logic clk;
    logic reset_n;
    logic cpu_valid;
    logic cpu_write;
    logic [`CACHE_ADDR_W-1:0] cpu_addr;
    logic [`CACHE_WORD_W-1:0] cpu_wdata;
    logic [`CACHE_WORD_W-1:0] cpu_rdata;
    logic cpu_ready;
    logic cpu_ack;
    logic mem_read;
    logic mem_write;
    logic [`CACHE_ADDR_W-1:0] mem_addr;
    cache_line_u mem_wdata;
    cache_line_u mem_rdata;
    logic mem_ready;
    logic mem_ack;
    int read_count;
    int write_count;
    logic [`CACHE_ADDR_W-1:0] last_read_addr;
    logic [`CACHE_ADDR_W-1:0] last_write_addr;

    // transaction table, one entry per cpu request
    logic        t_write [$];
    logic [15:0] t_addr [$];
    logic [15:0] t_wdata [$];
    logic [15:0] t_rdata [$];
    int          t_reads [$];
    int          t_writes [$];
    logic [15:0] t_wb_addr [$];
    bit          table_ready;

    // reference cache state, [set][way]
    bit          ref_valid [2][2];
    bit          ref_dirty [2][2];
    bit          ref_recent [2][2];
    bit [12:0]   ref_tag [2][2];
    logic [15:0] shadow [logic [15:0]];

    data_cache uut (.*);

    tb_mem_model u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic add_entry(input logic wr, input logic [15:0] addr, input logic [15:0] wdata,
                             input logic [15:0] rdata, input int reads, input int writes,
                             input logic [15:0] wb_addr);
        t_write.push_back(wr);
        t_addr.push_back(addr);
        t_wdata.push_back(wdata);
        t_rdata.push_back(rdata);
        t_reads.push_back(reads);
        t_writes.push_back(writes);
        t_wb_addr.push_back(wb_addr);
    endtask

    // lru and dirty rules applied to the reference state
    task automatic predict_access(input logic wr, input logic [15:0] addr,
                                  input logic [15:0] wdata, output int reads,
                                  output int writes, output logic [15:0] wb_addr,
                                  output logic [15:0] rdata);
        int s;
        int w;
        s = int'(addr[2]);
        reads = 0;
        writes = 0;
        wb_addr = '0;
        if (ref_valid[s][0] && ref_tag[s][0] == addr[15:3]) begin
            w = 0;
        end else if (ref_valid[s][1] && ref_tag[s][1] == addr[15:3]) begin
            w = 1;
        end else begin
            w = ref_recent[s][0] ? 1 : 0;
            if (ref_valid[s][w] && ref_dirty[s][w]) begin
                writes = 1;
                wb_addr = {ref_tag[s][w], addr[2], 2'b00};
            end
            reads = 1;
            ref_valid[s][w] = 1'b1;
            ref_tag[s][w] = addr[15:3];
            ref_dirty[s][w] = 1'b0;
        end
        if (wr) begin
            ref_dirty[s][w] = 1'b1;
            shadow[addr] = wdata;
        end
        ref_recent[s][w] = 1'b1;
        ref_recent[s][1-w] = 1'b0;
        rdata = shadow.exists(addr) ? shadow[addr] : addr ^ 16'hA5A5;
    endtask

    task automatic build_table();
        // fill, read hits, write hit and read back
        add_entry(0, 16'h0010, 16'h0000, 16'hA5B5, 1, 0, 16'h0000);
        add_entry(0, 16'h0011, 16'h0000, 16'hA5B4, 0, 0, 16'h0000);
        add_entry(0, 16'h0012, 16'h0000, 16'hA5B7, 0, 0, 16'h0000);
        add_entry(0, 16'h0013, 16'h0000, 16'hA5B6, 0, 0, 16'h0000);
        add_entry(1, 16'h0011, 16'h1234, 16'h1234, 0, 0, 16'h0000);
        add_entry(0, 16'h0011, 16'h0000, 16'h1234, 0, 0, 16'h0000);
        add_entry(0, 16'h0012, 16'h0000, 16'hA5B7, 0, 0, 16'h0000);
        // lines a, b, c all in set 0, c must evict b
        add_entry(0, 16'h0020, 16'h0000, 16'hA585, 1, 0, 16'h0000);
        add_entry(0, 16'h0010, 16'h0000, 16'hA5B5, 0, 0, 16'h0000);
        add_entry(0, 16'h0030, 16'h0000, 16'hA595, 1, 0, 16'h0000);
        add_entry(0, 16'h0013, 16'h0000, 16'hA5B6, 0, 0, 16'h0000);
        add_entry(0, 16'h0021, 16'h0000, 16'hA584, 1, 0, 16'h0000);
        // dirty line a goes back to memory, then returns from there
        add_entry(0, 16'h0032, 16'h0000, 16'hA597, 1, 1, 16'h0010);
        add_entry(0, 16'h0011, 16'h0000, 16'h1234, 1, 0, 16'h0000);
        // write misses in set 1
        add_entry(1, 16'h0005, 16'hBEEF, 16'hBEEF, 1, 0, 16'h0000);
        add_entry(0, 16'h0005, 16'h0000, 16'hBEEF, 0, 0, 16'h0000);
        add_entry(0, 16'h0004, 16'h0000, 16'hA5A1, 0, 0, 16'h0000);
        add_entry(0, 16'h0007, 16'h0000, 16'hA5A2, 0, 0, 16'h0000);
        add_entry(1, 16'h000C, 16'hC0DE, 16'hC0DE, 1, 0, 16'h0000);
        add_entry(1, 16'h0016, 16'h5A5A, 16'h5A5A, 1, 1, 16'h0004);
        add_entry(0, 16'h0005, 16'h0000, 16'hBEEF, 1, 1, 16'h000C);
        add_entry(0, 16'h000C, 16'h0000, 16'hC0DE, 1, 1, 16'h0014);
        add_entry(0, 16'h0017, 16'h0000, 16'hA5B2, 1, 0, 16'h0000);
    endtask

    initial begin
        int limit;
        wait (table_ready && reset_n === 1'b1);
        limit = t_addr.size() * 20;
        repeat (limit) @(posedge clk);
        $display("timeout: the transaction table did not finish within %0d cycles", limit);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int exp_reads;
        int exp_writes;
        int reads0;
        int writes0;
        int cycles;
        bit wb_first;
        logic [15:0] exp_wb;
        logic [15:0] exp_rdata;
        reset_n = 1'b0;
        cpu_valid = 1'b0;
        cpu_write = 1'b0;
        cpu_addr = '0;
        cpu_wdata = '0;
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);
        check_equal("cpu_ready", 32'(cpu_ready), 32'(0));
        check_equal("cpu_ack", 32'(cpu_ack), 32'(0));
        check_equal("mem_read", 32'(mem_read), 32'(0));
        check_equal("mem_write", 32'(mem_write), 32'(0));

        for (int i = 0; i < t_addr.size(); i++) begin
            // the hand-made table has to agree with the reference model
            predict_access(t_write[i], t_addr[i], t_wdata[i], exp_reads, exp_writes,
                           exp_wb, exp_rdata);
            check_equal("reference rdata", 32'(exp_rdata), 32'(t_rdata[i]));
            check_equal("reference reads", exp_reads, t_reads[i]);
            check_equal("reference writes", exp_writes, t_writes[i]);
            check_equal("reference victim", 32'(exp_wb), 32'(t_wb_addr[i]));

            @(posedge clk);
            reads0 = read_count;
            writes0 = write_count;
            cpu_valid <= 1'b1;
            cpu_write <= t_write[i];
            cpu_addr  <= t_addr[i];
            cpu_wdata <= t_wdata[i];
            cycles = 0;
            wb_first = 1'b0;
            do begin
                @(posedge clk);
                cycles = cycles + 1;
                // write-back already taken while no fill has been taken yet
                if (write_count != writes0 && read_count == reads0) begin
                    wb_first = 1'b1;
                end
            end while (!(cpu_ready === 1'b1 || cpu_ack === 1'b1));
            cpu_valid <= 1'b0;

            check_equal("cpu_ack", 32'(cpu_ack), 32'(t_write[i]));
            check_equal("cpu_ready", 32'(cpu_ready), 32'(!t_write[i]));
            if (!t_write[i]) begin
                check_equal("cpu_rdata", 32'(cpu_rdata), 32'(t_rdata[i]));
            end
            check_equal("line reads", read_count - reads0, t_reads[i]);
            check_equal("line writes", write_count - writes0, t_writes[i]);
            // a hit is answered in the request cycle
            if (t_reads[i] == 0 && t_writes[i] == 0) begin
                check_equal("hit latency", cycles, 1);
            end
            if (t_reads[i] != 0) begin
                check_equal("mem_addr of fill", 32'(last_read_addr),
                            32'({t_addr[i][15:2], 2'b00}));
            end
            if (t_writes[i] != 0) begin
                check_equal("mem_addr of write-back", 32'(last_write_addr),
                            32'(t_wb_addr[i]));
                check_equal("write-back before fill", 32'(wb_first), 32'(1));
            end
        end

        @(posedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- data_cache.f
+incdir+.
cache_pkg.sv
cache_tag_array.sv
cache_data_array.sv
cache_ctrl.sv
data_cache.sv
tb_mem_model.sv
tb_data_cache.sv

//--- run_sim.sh
#!/bin/sh
# build and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f data_cache.f \
    --top-module tb_data_cache -o sim_data_cache

./obj_dir/sim_data_cache > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
